// ==== fp_add.f ====
+incdir+.
fp_add_pkg.sv
fp_align_if.sv
fp_add_ctrl.sv
fp_align.sv
fp_mant_add.sv
fp_normalize.sv
fp_special.sv
fp_add_unit.sv
tb_fp_add_unit.sv

// ==== tb_fp_add_unit.sv ====
// Directed testbench for the add/sub unit; finite random operands stay far from overflow
`timescale 1ns/1ps

module tb_fp_add_unit;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 24;   // Reset check, 22 operand pairs and the stall
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 40 * NUM_TESTS;

  logic        clk_i, rst_n_i, clk_en_i, sub_i;
  logic [31:0] op_a_i, op_b_i, result_o;
  logic        valid_o, busy_o, overflow_o, underflow_o, invalid_o;
  integer      seed = 2;
  int          cycle_count = 0;

  fp_add_unit DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clk_en_i    (clk_en_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .sub_i       (sub_i),
    .result_o    (result_o),
    .valid_o     (valid_o),
    .busy_o      (busy_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .invalid_o   (invalid_o)
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  // Watchdog against a hung loop
  always @(posedge clk_i)
  begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  // Truncating align, carry or leading-zero normalize, exact zero gives +0
  function automatic logic [31:0] model_add(input logic [31:0] a, input logic [31:0] b,
                                            input logic sub);
    logic        sa, sb, rs;
    logic [7:0]  ea, eb, re;
    logic [23:0] ma, mb, mag;
    logic [24:0] total;
    int          lz;
    sa = a[31];
    sb = b[31] ^ sub;                          // a - b = a + (-b)
    ea = a[30:23];
    eb = b[30:23];
    ma = {|ea, a[22:0]};
    mb = {|eb, b[22:0]};
    if (ea > eb)       rs = sa;
    else if (eb > ea)  rs = sb;
    else if (mb > ma)  rs = sb;
    else               rs = sa;
    if (ea >= eb)
    begin
      re = ea;
      mb = mb >> (ea - eb);
    end
    else
    begin
      re = eb;
      ma = ma >> (eb - ea);
    end
    if (sa == sb)
    begin
      total = {1'b0, ma} + {1'b0, mb};
      mag   = total[24] ? total[24:1] : total[23:0];
      re    = re + total[24];
    end
    else
    begin
      mag = (ma >= mb) ? ma - mb : mb - ma;
      lz  = 0;
      while (lz < 24 && !mag[23])
      begin
        mag = mag << 1;
        lz++;
      end
      re = re - 8'(lz);
    end
    if (mag == '0)
      return 32'h0000_0000;
    return {rs, re, mag[22:0]};
  endfunction

  task automatic report_error(input string msg);
    $display("[FAIL] time %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic drive_operands(input logic [31:0] a, input logic [31:0] b, input logic sub);
    @(negedge clk_i);
    op_a_i = a;
    op_b_i = b;
    sub_i  = sub;
  endtask

  task automatic check_outputs(input logic [31:0] exp_res, input logic ovf, input logic unf,
                               input logic inv, input string name);
    assert (busy_o === 1'b0) else report_error({name, ": busy_o high while the result is valid"});
    assert (result_o === exp_res)
      else report_error($sformatf("%s: result %h, expected %h", name, result_o, exp_res));
    assert ({overflow_o, underflow_o, invalid_o} === {ovf, unf, inv})
      else report_error($sformatf("%s: flags ovf/unf/inv %b%b%b, expected %b%b%b", name,
                                  overflow_o, underflow_o, invalid_o, ovf, unf, inv));
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  // Second valid rise belongs to a loop that captured the held operands
  task automatic run_case(input logic [31:0] a, input logic [31:0] b, input logic sub,
                          input logic [31:0] exp_res, input logic [2:0] flags, input string name);
    drive_operands(a, b, sub);
    @(posedge valid_o);
    @(posedge valid_o);
    @(negedge clk_i);                          // Outputs settled, still in IDLE
    check_outputs(exp_res, flags[2], flags[1], flags[0], name);
  endtask

  task automatic test_known(input logic [31:0] a, input logic [31:0] b, input logic sub,
                            input logic [31:0] exp_res, input string name);
    assert (model_add(a, b, sub) === exp_res)
      else report_error({name, ": reference model disagrees with the hand value"});
    run_case(a, b, sub, exp_res, 3'b000, name);
  endtask

  task automatic test_stall(input logic [31:0] a, input logic [31:0] b, input logic sub);
    logic [31:0] held;
    drive_operands(a, b, sub);
    @(posedge valid_o);
    @(negedge clk_i);
    @(negedge clk_i);                          // Capture done, now in PREPARE
    clk_en_i = 1'b0;
    held     = result_o;
    repeat (10)
    begin
      @(negedge clk_i);
      assert (valid_o === 1'b0 && busy_o === 1'b1 && result_o === held)
        else report_error("stall: outputs moved while clk_en_i was low");
    end
    clk_en_i = 1'b1;
    @(posedge valid_o);
    @(negedge clk_i);
    check_outputs(model_add(a, b, sub), 1'b0, 1'b0, 1'b0, "stall");
  endtask

  initial
  begin
    logic [7:0]  ea, eb;
    logic [31:0] a, b;
    logic        sub;
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    clk_en_i = 1'b1;
    op_a_i   = '0;
    op_b_i   = '0;
    sub_i    = 1'b0;

    // Reset state
    repeat (RESET_CYCLES)
    begin
      @(negedge clk_i);
      assert ({valid_o, busy_o, overflow_o, underflow_o, invalid_o} === 5'b0)
        else report_error("outputs not cleared during reset");
    end
    rst_n_i = 1'b1;
    assert ({valid_o, busy_o, overflow_o, underflow_o, invalid_o} === 5'b0)
      else report_error("outputs not cleared right after reset");
    repeat (3)
    begin
      @(negedge clk_i);
      assert (valid_o === 1'b0) else report_error("valid_o high before the first result");
    end

    test_known(32'h3FC0_0000, 32'h4010_0000, 1'b0, 32'h4070_0000, "1.5 + 2.25");
    test_known(32'h4040_0000, 32'h3F80_0000, 1'b0, 32'h4080_0000, "3.0 + 1.0");   // Carry
    test_known(32'h3F80_0000, 32'h3F40_0000, 1'b1, 32'h3E80_0000, "1.0 - 0.75");
    test_known(32'h4060_0000, 32'h4060_0000, 1'b1, 32'h0000_0000, "3.5 - 3.5");
    test_known(32'h4000_0000, 32'h40A0_0000, 1'b1, 32'hC040_0000, "2.0 - 5.0");

    for (int i = 0; i < 12; i++)
    begin
      ea  = 8'(100 + {$random(seed)} % 50);
      eb  = 8'(ea - 20 + {$random(seed)} % 41);  // Within 20 of ea
      a   = {1'($random(seed)), ea, 23'($random(seed))};
      b   = {1'($random(seed)), eb, 23'($random(seed))};
      sub = 1'($random(seed));
      run_case(a, b, sub, model_add(a, b, sub), 3'b000, $sformatf("random %0d", i));
    end

    // Carry out of the top finite exponent
    run_case(32'h7F00_0000, 32'h7F00_0000, 1'b0, 32'h7F80_0000, 3'b100, "2^127 + 2^127");

    // Infinities, flags ordered ovf/unf/inv
    run_case(32'h7F80_0000, 32'h3F80_0000, 1'b0, 32'h7F80_0000, 3'b100, "+inf + 1.0");
    run_case(32'hFF80_0000, 32'h3F80_0000, 1'b0, 32'hFF80_0000, 3'b010, "-inf + 1.0");
    run_case(32'h3F80_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000, 3'b010, "1.0 - +inf");
    run_case(32'h7F80_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000, 3'b001, "+inf - +inf");

    test_stall(32'h3FC0_0000, 32'h4010_0000, 1'b1);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== fp_add_unit.sv ====
// Free-running unit with no handshake; a result is valid for the single IDLE cycle after each loop
`timescale 1ns/1ps

module fp_add_unit (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        clk_en_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  input  logic        sub_i,
  output logic [31:0] result_o,
  output logic        valid_o,
  output logic        busy_o,
  output logic        overflow_o,
  output logic        underflow_o,
  output logic        invalid_o
);

  fp_add_pkg::fp_op_e  op;
  fp_add_pkg::float_t  op_a, op_b;
  fp_add_pkg::float_t  cap_a, cap_b;
  fp_add_pkg::float_t  special_res;
  fp_add_pkg::float_t  result;
  logic                capture_en, prep_en, add_en, norm_en;
  logic                special;
  logic [24:0]         sum;          // Significand sum with carry

  assign op     = sub_i ? fp_add_pkg::FP_SUB : fp_add_pkg::FP_ADD;
  assign op_a   = fp_add_pkg::float_t'(op_a_i);
  assign op_b   = fp_add_pkg::float_t'(op_b_i);
  assign result_o = result;

  fp_align_if align_if ();

  //////////////////////////////////////////////////
  // Sequencer and datapath stages
  //////////////////////////////////////////////////

  fp_add_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clk_en_i     (clk_en_i),
    .capture_en_o (capture_en),
    .prep_en_o    (prep_en),
    .add_en_o     (add_en),
    .norm_en_o    (norm_en),
    .valid_o      (valid_o),
    .busy_o       (busy_o)
  );

  fp_align u_align (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .capture_en_i (capture_en),
    .prep_en_i    (prep_en),
    .op_a_i       (op_a),
    .op_b_i       (op_b),
    .op_i         (op),
    .align        (align_if.align_mp),
    .cap_a_o      (cap_a),
    .cap_b_o      (cap_b)
  );

  fp_mant_add u_mant_add (
    .clk_i    (clk_i),
    .add_en_i (add_en),
    .align    (align_if.add_mp),
    .sum_o    (sum)
  );

  fp_normalize u_normalize (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .norm_en_i     (norm_en),
    .sum_i         (sum),
    .align         (align_if.norm_mp),
    .special_i     (special),
    .special_res_i (special_res),
    .result_o      (result)
  );

  fp_special u_special (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .norm_en_i     (norm_en),
    .cap_a_i       (cap_a),
    .cap_b_i       (cap_b),
    .special_o     (special),
    .special_res_o (special_res),
    .overflow_o    (overflow_o),
    .underflow_o   (underflow_o),
    .invalid_o     (invalid_o)
  );

endmodule

// ==== fp_special.sv ====
// Only infinities are special; NaN operands run through the datapath like finite values
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_special (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                norm_en_i,
  input  fp_add_pkg::float_t  cap_a_i,
  input  fp_add_pkg::float_t  cap_b_i,
  output logic                special_o,
  output fp_add_pkg::float_t  special_res_o,
  output logic                overflow_o,
  output logic                underflow_o,
  output logic                invalid_o
);

  logic                  a_inf, b_inf;
  logic                  inf_mixed, any_pos_inf;
  logic [`FP_EXP_W:0]    exp_diff;
  logic [`FP_EXP_W-1:0]  exp_big;
  logic [`FP_SIG_W-1:0]  sig_big, sig_small;
  logic [`FP_SIG_W:0]    sum_big;
  logic                  fin_ovf;
  logic                  ovf_d, unf_d, inv_d;

  assign a_inf = (cap_a_i.exponent == `FP_EXP_INF) && (cap_a_i.mantissa == '0);
  assign b_inf = (cap_b_i.exponent == `FP_EXP_INF) && (cap_b_i.mantissa == '0);

  assign inf_mixed   = a_inf && b_inf && (cap_a_i.sign != cap_b_i.sign);
  assign any_pos_inf = (a_inf && !cap_a_i.sign) || (b_inf && !cap_b_i.sign);

  assign special_o              = a_inf || b_inf;
  assign special_res_o.sign     = inf_mixed || !any_pos_inf;  // Mixed pair gives -inf
  assign special_res_o.exponent = `FP_EXP_INF;
  assign special_res_o.mantissa = '0;

  //////////////////////////////////////////////////
  // Finite overflow
  //////////////////////////////////////////////////

  // Like-sign carry out of the top finite exponent lands on all ones
  assign exp_diff  = {1'b0, cap_a_i.exponent} - {1'b0, cap_b_i.exponent};
  assign exp_big   = exp_diff[`FP_EXP_W] ? cap_b_i.exponent : cap_a_i.exponent;
  assign sig_big   = exp_diff[`FP_EXP_W] ? {1'b1, cap_b_i.mantissa} : {1'b1, cap_a_i.mantissa};
  assign sig_small = exp_diff[`FP_EXP_W] ?
                     ({|cap_a_i.exponent, cap_a_i.mantissa} >> -exp_diff[`FP_EXP_W-1:0]) :
                     ({|cap_b_i.exponent, cap_b_i.mantissa} >> exp_diff[`FP_EXP_W-1:0]);
  assign sum_big   = {1'b0, sig_big} + {1'b0, sig_small};
  assign fin_ovf   = (cap_a_i.sign == cap_b_i.sign) &&
                     (exp_big == `FP_EXP_INF - 1'b1) && sum_big[`FP_SIG_W];

  assign inv_d = inf_mixed;
  assign ovf_d = special_o ? (!inf_mixed && any_pos_inf) : fin_ovf;
  assign unf_d = special_o && !inf_mixed && !any_pos_inf;

  // Flags move with result_o
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      invalid_o   <= 1'b0;
    end
    else if (norm_en_i)
    begin
      overflow_o  <= ovf_d;
      underflow_o <= unf_d;
      invalid_o   <= inv_d;
    end
  end

endmodule

// ==== fp_normalize.sv ====
// No rounding and no denormal output; exponent under- or overflow from the shift wraps unchecked
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_normalize (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                norm_en_i,
  input  logic [`FP_SIG_W:0]  sum_i,
  fp_align_if.norm_mp         align,
  input  logic                special_i,
  input  fp_add_pkg::float_t  special_res_i,
  output fp_add_pkg::float_t  result_o
);

  logic                  eff_add;
  logic [`FP_SIG_W:0]    mag_ext;
  logic [`FP_SIG_W-1:0]  mag;
  logic [`FP_LZC_W-1:0]  lzc;
  logic [`FP_SIG_W-1:0]  mant_n;
  logic [`FP_EXP_W-1:0]  exp_n;
  fp_add_pkg::float_t    res_d;
  fp_add_pkg::float_t    result_q;

  assign eff_add = (align.sign_a == align.sign_b);

  // Absolute value of the difference
  assign mag_ext = sum_i[`FP_SIG_W] ? -sum_i : sum_i;
  assign mag     = mag_ext[`FP_SIG_W-1:0];

  //////////////////////////////////////////////////
  // Leading-zero count
  //////////////////////////////////////////////////

  // Highest set bit wins, all zero gives FP_SIG_W
  always_comb
  begin
    lzc = `FP_LZC_W'(`FP_SIG_W);
    for (int i = 0; i < `FP_SIG_W; i++)
    begin
      if (mag[i])
        lzc = `FP_LZC_W'(`FP_SIG_W - 1 - i);
    end
  end

  //////////////////////////////////////////////////
  // Normalization
  //////////////////////////////////////////////////

  always_comb
  begin
    if (eff_add && sum_i[`FP_SIG_W])
    begin
      mant_n = sum_i[`FP_SIG_W:1];      // Carry, shift right once
      exp_n  = align.res_exp + 1'b1;
    end
    else if (eff_add)
    begin
      mant_n = sum_i[`FP_SIG_W-1:0];
      exp_n  = align.res_exp;
    end
    else
    begin
      mant_n = mag << lzc;
      exp_n  = align.res_exp - `FP_EXP_W'(lzc);
    end

    res_d.sign     = align.res_sign;
    res_d.exponent = exp_n;
    res_d.mantissa = mant_n[`FP_MAN_W-1:0];  // Hidden bit dropped

    if (mant_n == '0)
      res_d = '0;                          // Exact zero is +0
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      result_q <= '0;
    else if (norm_en_i)
      result_q <= special_i ? special_res_i : res_d;
  end

  assign result_o = result_q;

endmodule

// ==== fp_mant_add.sv ====
// Sum is a raw 25-bit value; for unlike signs it is two's complement and may be negative
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_mant_add (
  input  logic                 clk_i,
  input  logic                 add_en_i,
  fp_align_if.add_mp           align,
  output logic [`FP_SIG_W:0]   sum_o
);

  logic [`FP_SIG_W:0] sig_a_ext, sig_b_ext;
  logic [`FP_SIG_W:0] sum_d;
  logic [`FP_SIG_W:0] sum_q;  // Top bit is carry or sign

  assign sig_a_ext = {1'b0, align.sig_a};
  assign sig_b_ext = {1'b0, align.sig_b};

  //////////////////////////////////////////////////
  // Add or subtract by sign pair
  //////////////////////////////////////////////////

  always_comb
  begin
    case ({align.sign_a, align.sign_b})
      2'b01:   sum_d = sig_a_ext - sig_b_ext;  // A positive
      2'b10:   sum_d = sig_b_ext - sig_a_ext;  // B positive
      default: sum_d = sig_a_ext + sig_b_ext;  // Like signs, magnitude add
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (add_en_i)
      sum_q <= sum_d;
  end

  assign sum_o = sum_q;

endmodule

// ==== fp_align.sv ====
// Shift amounts past the significand width flush the smaller operand to zero; shifted-out bits are lost
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_align (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                capture_en_i,
  input  logic                prep_en_i,
  input  fp_add_pkg::float_t  op_a_i,
  input  fp_add_pkg::float_t  op_b_i,
  input  fp_add_pkg::fp_op_e  op_i,
  fp_align_if.align_mp        align,
  output fp_add_pkg::float_t  cap_a_o,
  output fp_add_pkg::float_t  cap_b_o
);

  fp_add_pkg::float_t     cap_a_q, cap_b_q;
  logic [`FP_SIG_W-1:0]   sig_a, sig_b;
  logic [`FP_EXP_W:0]     exp_diff;      // Extra bit holds the borrow
  logic [`FP_EXP_W-1:0]   shift_amt;
  logic                   a_larger;      // A exponent >= B exponent
  logic                   exp_equal;
  logic                   res_sign_d;

  //////////////////////////////////////////////////
  // Operand capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end
    else if (capture_en_i)
    begin
      cap_a_q      <= op_a_i;
      cap_b_q      <= op_b_i;
      cap_b_q.sign <= op_b_i.sign ^ (op_i == fp_add_pkg::FP_SUB);  // a - b = a + (-b)
    end
  end

  // Hidden bit is zero only for a zero exponent
  assign sig_a = {|cap_a_q.exponent, cap_a_q.mantissa};
  assign sig_b = {|cap_b_q.exponent, cap_b_q.mantissa};

  //////////////////////////////////////////////////
  // Exponent compare
  //////////////////////////////////////////////////

  assign exp_diff  = {1'b0, cap_a_q.exponent} - {1'b0, cap_b_q.exponent};
  assign a_larger  = ~exp_diff[`FP_EXP_W];
  assign shift_amt = a_larger ? exp_diff[`FP_EXP_W-1:0] : -exp_diff[`FP_EXP_W-1:0];
  assign exp_equal = (exp_diff == '0);

  always_comb
  begin
    if (!exp_equal)
      res_sign_d = a_larger ? cap_a_q.sign : cap_b_q.sign;
    else if (sig_b > sig_a)
      res_sign_d = cap_b_q.sign;
    else
      res_sign_d = cap_a_q.sign;  // Also the tie, cancels to zero anyway
  end

  // Alignment, smaller operand moves right
  always_ff @(posedge clk_i)
  begin
    if (prep_en_i)
    begin
      align.sign_a   <= cap_a_q.sign;
      align.sign_b   <= cap_b_q.sign;
      align.sig_a    <= a_larger ? sig_a : (sig_a >> shift_amt);
      align.sig_b    <= a_larger ? (sig_b >> shift_amt) : sig_b;
      align.res_sign <= res_sign_d;
      align.res_exp  <= a_larger ? cap_a_q.exponent : cap_b_q.exponent;
    end
  end

  assign cap_a_o = cap_a_q;
  assign cap_b_o = cap_b_q;

endmodule

// ==== fp_add_ctrl.sv ====
// Free-running four-state loop; clk_en_i low freezes the state and masks every strobe
`timescale 1ns/1ps

module fp_add_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic clk_en_i,
  output logic capture_en_o,
  output logic prep_en_o,
  output logic add_en_o,
  output logic norm_en_o,
  output logic valid_o,
  output logic busy_o
);

  fp_add_pkg::add_state_e state_q, state_d;
  logic                   have_result_q;  // Set once the first loop has finished

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_q <= fp_add_pkg::IDLE;
    else if (clk_en_i)
      state_q <= state_d;
  end

  always_comb
  begin
    case (state_q)
      fp_add_pkg::IDLE:      state_d = fp_add_pkg::PREPARE;
      fp_add_pkg::PREPARE:   state_d = fp_add_pkg::ADDITION;
      fp_add_pkg::ADDITION:  state_d = fp_add_pkg::NORMALIZE;
      default:               state_d = fp_add_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      have_result_q <= 1'b0;
    else if (norm_en_o)
      have_result_q <= 1'b1;
  end

  // One strobe per stage, only on enabled cycles
  assign capture_en_o = clk_en_i && (state_q == fp_add_pkg::IDLE);
  assign prep_en_o    = clk_en_i && (state_q == fp_add_pkg::PREPARE);
  assign add_en_o     = clk_en_i && (state_q == fp_add_pkg::ADDITION);
  assign norm_en_o    = clk_en_i && (state_q == fp_add_pkg::NORMALIZE);

  assign valid_o = (state_q == fp_add_pkg::IDLE) && have_result_q;
  assign busy_o  = (state_q != fp_add_pkg::IDLE);

endmodule

// ==== fp_align_if.sv ====
// Aligned operands are valid from the PREPARE edge until the next PREPARE edge
`timescale 1ns/1ps
`include "fp_add_settings.svh"

interface fp_align_if;

  // Effective signs, B already flipped for subtraction
  logic                 sign_a;
  logic                 sign_b;

  // Significands with hidden bit, smaller one shifted right
  logic [`FP_SIG_W-1:0] sig_a;
  logic [`FP_SIG_W-1:0] sig_b;

  logic                 res_sign;   // Sign of the larger magnitude
  logic [`FP_EXP_W-1:0] res_exp;    // Larger exponent

  modport align_mp (
    output sign_a, sign_b, sig_a, sig_b, res_sign, res_exp
  );

  modport add_mp (
    input sign_a, sign_b, sig_a, sig_b
  );

  // Normalizer needs the signs only to tell add from subtract
  modport norm_mp (
    input sign_a, sign_b, res_sign, res_exp
  );

endinterface

// ==== fp_add_pkg.sv ====
// Types shared by the add/sub unit; widths come from the settings header
`include "fp_add_settings.svh"

package fp_add_pkg;

  //////////////////////////////////////////////////
  // Data format
  //////////////////////////////////////////////////

  // IEEE 754 single, sign in the top bit
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exponent;
    logic [`FP_MAN_W-1:0] mantissa;
  } float_t;

  //////////////////////////////////////////////////
  // Opcodes and states
  //////////////////////////////////////////////////

  typedef enum logic {
    FP_ADD = 1'b0,
    FP_SUB = 1'b1     // Flips the sign of operand B
  } fp_op_e;

  // Fixed loop, one enabled cycle per state
  typedef enum logic [`FP_STATE_W-1:0] {
    IDLE      = 2'd0,  // Operand capture
    PREPARE   = 2'd1,  // Exponent compare and alignment
    ADDITION  = 2'd2,  // Significand add/sub
    NORMALIZE = 2'd3   // Carry fix or leading-zero shift
  } add_state_e;

endpackage

// ==== fp_add_settings.svh ====
// IEEE single precision only; changing a width here does not retarget the datapath to another format
`ifndef FP_ADD_SETTINGS_SVH
`define FP_ADD_SETTINGS_SVH

//////////////////////////////////////////////////
// Float format
//////////////////////////////////////////////////

`define FP_EXP_W   8        // Exponent field
`define FP_MAN_W   23       // Stored mantissa field
`define FP_SIG_W   24       // Significand with hidden bit

// Leading-zero count must hold the value FP_SIG_W
`define FP_LZC_W   5

// Exponent value that marks infinity
`define FP_EXP_INF 8'hFF

//////////////////////////////////////////////////
// Sequencer
//////////////////////////////////////////////////

`define FP_STATE_W 2        // Four states

`endif
